/* flist.f */
+incdir+sim
verilog/mem_bus_pkg.sv
verilog/mem_port_pkg.sv
verilog/mem_port_ctrl.sv
verilog/req_capture.sv
verilog/mem_issue.sv
verilog/mem_port_top.sv
sim/tb_mem_port.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the memory port testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_mem_port -f flist.f

./obj_dir/Vtb_mem_port | tee sim.log

if grep -qx "Test passed" sim.log; then
  exit 0
else
  exit 1
fi

/* sim/tb_mem_port_tests.svh */
// ------------------------------------------------------------
// Compare tasks
// ------------------------------------------------------------

task automatic check_mem_req(string name, mem_req_t exp, mem_req_t act);
  if (act !== exp)
  begin
    error_count++;
    $display("[FAIL] %s expected %h actual %h", name, exp, act);
  end
endtask

task automatic check_bit(string name, logic exp, logic act);
  if (act !== exp)
  begin
    error_count++;
    $display("[FAIL] %s expected %h actual %h", name, exp, act);
  end
endtask

task automatic check_count(int exp, int act);
  if (act != exp)
  begin
    error_count++;
    $display("Error: wrong number of memory beats, expected %0d but saw %0d", exp, act);
  end
endtask

// ------------------------------------------------------------
// Request building and expected beats
// ------------------------------------------------------------

function automatic bus_req_t make_req(logic [31:0] address, logic [31:0] writedata,
                                      logic [3:0] byteen, logic [15:0] numblocks,
                                      logic [15:0] stride, logic [15:0] length, logic wren);
  bus_req_t r;
  r.address         = address;
  r.writedata       = writedata;
  r.byteen          = byteen;
  r.numblocks       = numblocks;
  r.prefetch.stride = stride;
  r.prefetch.length = length;
  r.wren            = wren;
  return r;
endfunction

// Beat k sits k strides past the request address and wraps at 2^32
function automatic mem_req_t expected_beat(bus_req_t r, int k);
  mem_req_t m;
  m.address   = r.address + 32'(k) * 32'(r.prefetch.stride);
  m.writedata = r.writedata;
  m.byteen    = r.byteen;
  m.numblocks = r.numblocks;
  m.wren      = r.wren;
  return m;
endfunction

task automatic push_expected(bus_req_t r);
  for (int k = 0; k <= int'(r.prefetch.length); k++)
  begin
    exp_q.push_back(expected_beat(r, k));
  end
endtask

task automatic start_test(logic stall);
  beat_q.delete();
  exp_q.delete();
  stall_mode = stall;
endtask

// Holds the request until the port takes it, then drops bus_valid
task automatic send_bus_req(bus_req_t r);
  @(negedge clk);
  bus_req   = r;
  bus_valid = 1'b1;
  while (!bus_ready)
  begin
    @(negedge clk);
  end
  beats_at_accept = beat_q.size();
  @(posedge clk);
  @(negedge clk);
  bus_valid = 1'b0;
endtask

task automatic wait_idle();
  while (!bus_idle)
  begin
    @(negedge clk);
  end
endtask

task automatic compare_beats();
  check_count(exp_q.size(), beat_q.size());
  for (int i = 0; i < exp_q.size() && i < beat_q.size(); i++)
  begin
    check_mem_req("mem_req", exp_q[i], beat_q[i]);
  end
endtask

task automatic run_single(bus_req_t r, logic stall);
  start_test(stall);
  push_expected(r);
  send_bus_req(r);
  wait_idle();
  compare_beats();
endtask

// ------------------------------------------------------------
// Directed tests
// ------------------------------------------------------------

task automatic single_write();
  check_bit("mem_valid", 1'b0, mem_valid);
  check_bit("bus_idle", 1'b1, bus_idle);
  check_bit("bus_ready", 1'b1, bus_ready);
  run_single(make_req(32'h0000_1230, 32'hDEAD_BEEF, 4'hF, 16'd1, 16'h0040, 16'd0, 1'b1), 1'b0);
endtask

task automatic prefetch_read();
  run_single(make_req(32'h0004_0000, 32'h1111_2222, 4'h3, 16'd4, 16'd64, 16'd5, 1'b0), 1'b0);
endtask

task automatic address_wrap();
  run_single(make_req(32'hFFFF_FF00, 32'hA5A5_5A5A, 4'hC, 16'd2, 16'h8000, 16'd3, 1'b0), 1'b0);
endtask

task automatic random_stall();
  run_single(make_req(32'h1000_0000, 32'hCAFE_F00D, 4'h5, 16'd8, 16'd4, 16'd7, 1'b1), 1'b1);
endtask

// The second request is offered while the first is still issuing its beats
task automatic back_to_back_requests();
  bus_req_t a;
  bus_req_t b;
  a = make_req(32'h0000_2000, 32'h0BAD_0001, 4'hF, 16'd1, 16'h0010, 16'd2, 1'b1);
  b = make_req(32'h0000_3000, 32'h0BAD_0002, 4'h1, 16'd3, 16'h0020, 16'd3, 1'b0);
  start_test(1'b0);
  push_expected(a);
  push_expected(b);
  send_bus_req(a);
  send_bus_req(b);
  if (beats_at_accept != int'(a.prefetch.length) + 1)
  begin
    error_count++;
    $display("Error: the second request was taken before the first one had finished its beats");
  end
  wait_idle();
  compare_beats();
endtask

/* sim/tb_mem_port.sv */
module tb_mem_port;

  import mem_bus_pkg::*;
  import mem_port_pkg::*;

  // Beats summed over all directed tests set the watchdog length
  localparam int TOTAL_BEATS   = 26;
  localparam int STALL_BOUND   = 20;
  localparam int MARGIN_CYCLES = 100;

  logic     clk;
  logic     resetn;
  bus_req_t bus_req;
  logic     bus_valid;
  logic     bus_ready;
  logic     bus_idle;
  mem_req_t mem_req;
  logic     mem_valid;
  logic     mem_ready;

  // Responder mode, beats seen on the memory side and the expected stream
  logic     stall_mode;
  mem_req_t beat_q[$];
  mem_req_t exp_q[$];
  int       beats_at_accept;
  int       error_count;
  int       beat_total;

  mem_port_top mem_port_top_inst (
    .clk       (clk),
    .resetn    (resetn),
    .bus_req   (bus_req),
    .bus_valid (bus_valid),
    .bus_ready (bus_ready),
    .bus_idle  (bus_idle),
    .mem_req   (mem_req),
    .mem_valid (mem_valid),
    .mem_ready (mem_ready)
  );

  `include "tb_mem_port_tests.svh"

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ------------------------------------------------------------
  // Memory responder
  // ------------------------------------------------------------

  // A beat is logged on the falling edge before the rising edge that moves it
  initial
  begin : memory_responder
    mem_req_t held_req;
    logic     stalled;
    void'($urandom(57));
    held_req = '0;
    stalled  = 1'b0;
    forever
    begin
      @(negedge clk);
      if (stalled)
      begin
        check_bit("mem_valid", 1'b1, mem_valid);
        check_mem_req("mem_req", held_req, mem_req);
      end
      if (stall_mode)
      begin
        mem_ready = ($urandom % 4) != 0;
      end
      else
      begin
        mem_ready = 1'b1;
      end
      if (mem_valid && mem_ready)
      begin
        beat_q.push_back(mem_req);
        beat_total++;
      end
      stalled  = mem_valid && !mem_ready;
      held_req = mem_req;
    end
  end

  initial
  begin : watchdog
    repeat (TOTAL_BEATS * STALL_BOUND + MARGIN_CYCLES) @(posedge clk);
    $display("Timeout: the port stopped making progress before all tests finished");
    $display("Test failed");
    $finish;
  end

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------

  initial
  begin
    resetn          = 1'b0;
    bus_req         = '0;
    bus_valid       = 1'b0;
    mem_ready       = 1'b0;
    stall_mode      = 1'b0;
    beats_at_accept = 0;
    error_count     = 0;
    beat_total      = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    resetn = 1'b1;

    single_write();
    prefetch_read();
    address_wrap();
    random_stall();
    back_to_back_requests();

    $display("Run complete with %0d errors over %0d memory beats", error_count, beat_total);
    if (error_count == 0)
    begin
      $display("Test passed");
    end
    else
    begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* verilog/mem_port_top.sv */
module mem_port_top (
  input  logic                   clk,
  input  logic                   resetn,

  // Processor-side bus
  input  mem_bus_pkg::bus_req_t  bus_req,
  input  logic                   bus_valid,
  output logic                   bus_ready,
  output logic                   bus_idle,

  // Memory controller side
  output mem_port_pkg::mem_req_t mem_req,
  output logic                   mem_valid,
  input  logic                   mem_ready
);

  import mem_port_pkg::*;

  logic     capture_load;
  logic     issue_load;
  logic     step;
  logic     last;
  logic     beat_done;
  mem_req_t cur_req;

  mem_port_ctrl mem_port_ctrl_inst (
    .clk          (clk),
    .resetn       (resetn),
    .bus_valid    (bus_valid),
    .bus_ready    (bus_ready),
    .bus_idle     (bus_idle),
    .last         (last),
    .beat_done    (beat_done),
    .capture_load (capture_load),
    .issue_load   (issue_load),
    .step         (step)
  );

  req_capture req_capture_inst (
    .clk          (clk),
    .resetn       (resetn),
    .capture_load (capture_load),
    .step         (step),
    .bus_req      (bus_req),
    .cur_req      (cur_req),
    .last         (last)
  );

  mem_issue mem_issue_inst (
    .clk          (clk),
    .resetn       (resetn),
    .issue_load   (issue_load),
    .cur_req      (cur_req),
    .mem_ready    (mem_ready),
    .mem_req      (mem_req),
    .mem_valid    (mem_valid),
    .beat_done    (beat_done)
  );

endmodule

/* verilog/mem_issue.sv */
module mem_issue (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic                   issue_load,
  input  mem_port_pkg::mem_req_t cur_req,
  input  logic                   mem_ready,
  output mem_port_pkg::mem_req_t mem_req,
  output logic                   mem_valid,
  output logic                   beat_done
);

  // ------------------------------------------------------------
  // Handshake
  // ------------------------------------------------------------

  // A beat moves on any edge where valid and ready are both high
  assign beat_done = mem_valid && mem_ready;

  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      mem_valid <= 1'b0;
    end
    else if (issue_load)
    begin
      mem_valid <= 1'b1;
    end
    else if (beat_done)
    begin
      mem_valid <= 1'b0;
    end
  end

  // ------------------------------------------------------------
  // Output register
  // ------------------------------------------------------------

  // Loaded once per beat and then held, so the beat stays stable while
  // the memory stalls and the capture registers may move on freely
  always_ff @(posedge clk)
  begin
    if (issue_load)
    begin
      mem_req <= cur_req;
    end
  end

endmodule

/* verilog/req_capture.sv */
module req_capture (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic                   capture_load,
  input  logic                   step,
  input  mem_bus_pkg::bus_req_t  bus_req,
  output mem_port_pkg::mem_req_t cur_req,
  output logic                   last
);

  import mem_bus_pkg::*;

  logic [ADDR_W-1:0]   address;
  logic [DATA_W-1:0]   writedata;
  logic [BYTEEN_W-1:0] byteen;
  logic [NUMBLK_W-1:0] numblocks;
  logic                wren;
  logic [PF_W-1:0]     stride;
  logic [PF_W-1:0]     remaining;

  // ------------------------------------------------------------
  // Request payload
  // ------------------------------------------------------------

  // The address wraps modulo 2^32 when the stride carries past the top
  always_ff @(posedge clk)
  begin
    if (capture_load)
    begin
      address   <= bus_req.address;
      writedata <= bus_req.writedata;
      byteen    <= bus_req.byteen;
      numblocks <= bus_req.numblocks;
      wren      <= bus_req.wren;
      stride    <= bus_req.prefetch.stride;
    end
    else if (step)
    begin
      address <= address + ADDR_W'(stride);
    end
  end

  // ------------------------------------------------------------
  // Prefetch countdown
  // ------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      remaining <= '0;
    end
    else if (capture_load)
    begin
      remaining <= bus_req.prefetch.length;
    end
    else if (step)
    begin
      remaining <= remaining - 1'b1;
    end
  end

  assign last = (remaining == '0);

  always_comb
  begin
    cur_req.address   = address;
    cur_req.writedata = writedata;
    cur_req.byteen    = byteen;
    cur_req.numblocks = numblocks;
    cur_req.wren      = wren;
  end

endmodule

/* verilog/mem_port_ctrl.sv */
module mem_port_ctrl (
  input  logic clk,
  input  logic resetn,

  // Bus side handshake and status
  input  logic bus_valid,
  output logic bus_ready,
  output logic bus_idle,

  // Datapath control
  input  logic last,
  input  logic beat_done,
  output logic capture_load,
  output logic issue_load,
  output logic step
);

  import mem_port_pkg::*;

  port_state_t state;
  port_state_t state_next;

  // ------------------------------------------------------------
  // Next state
  // ------------------------------------------------------------

  always_comb
  begin
    state_next = state;
    case (state)
      PORT_IDLE:
      begin
        // Only one request is in flight, so a new one is taken only here
        if (bus_valid)
        begin
          state_next = PORT_ISSUE;
        end
      end
      PORT_ISSUE:
      begin
        // Memory back-pressure keeps us here for as long as it lasts
        if (beat_done)
        begin
          state_next = PORT_DONE;
        end
      end
      PORT_DONE:
      begin
        if (last)
        begin
          state_next = PORT_IDLE;
        end
        else
        begin
          state_next = PORT_PREFETCH;
        end
      end
      PORT_PREFETCH:
      begin
        state_next = PORT_ISSUE;
      end
      default:
      begin
        state_next = PORT_IDLE;
      end
    endcase
  end

  // ------------------------------------------------------------
  // State register and issue pulse
  // ------------------------------------------------------------

  // The issue pulse is registered on entry to ISSUE, so the output stage
  // loads one cycle after the capture registers have settled
  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      state      <= PORT_IDLE;
      issue_load <= 1'b0;
    end
    else
    begin
      state      <= state_next;
      issue_load <= (state != PORT_ISSUE) && (state_next == PORT_ISSUE);
    end
  end

  // ------------------------------------------------------------
  // Decoded outputs
  // ------------------------------------------------------------

  assign bus_idle     = (state == PORT_IDLE);
  assign bus_ready    = bus_idle;
  assign capture_load = bus_ready && bus_valid;

  // Address advance and length decrement happen once per prefetch step
  assign step         = (state == PORT_PREFETCH);

endmodule

/* verilog/mem_port_pkg.sv */
package mem_port_pkg;

  // ------------------------------------------------------------
  // Memory-side request
  // ------------------------------------------------------------

  // The bus request without its prefetch descriptor, 85 bits in all
  typedef struct packed {
    logic [mem_bus_pkg::ADDR_W-1:0]   address;
    logic [mem_bus_pkg::DATA_W-1:0]   writedata;
    logic [mem_bus_pkg::BYTEEN_W-1:0] byteen;
    logic [mem_bus_pkg::NUMBLK_W-1:0] numblocks;
    logic                             wren;
  } mem_req_t;

  // ------------------------------------------------------------
  // Port controller states
  // ------------------------------------------------------------

  // ISSUE waits for the memory handshake, DONE decides between
  // returning to idle and stepping to the next prefetch address
  typedef enum logic [2:0] {
    PORT_IDLE     = 3'd0,
    PORT_ISSUE    = 3'd1,
    PORT_DONE     = 3'd2,
    PORT_PREFETCH = 3'd3
  } port_state_t;

endpackage

/* verilog/mem_bus_pkg.sv */
package mem_bus_pkg;

  // ------------------------------------------------------------
  // Processor-side bus widths
  // ------------------------------------------------------------

  localparam int ADDR_W   = 32;
  localparam int DATA_W   = 32;
  localparam int BYTEEN_W = DATA_W / 8;
  localparam int NUMBLK_W = 16;

  // Both halves of the prefetch word share this width
  localparam int PF_W     = 16;

  // ------------------------------------------------------------
  // Request types
  // ------------------------------------------------------------

  // Stride sits in the upper half of the word and length in the lower half
  typedef struct packed {
    logic [PF_W-1:0] stride;
    logic [PF_W-1:0] length;
  } prefetch_t;

  // One bus request as offered by the processor, 117 bits in all
  typedef struct packed {
    logic [ADDR_W-1:0]   address;
    logic [DATA_W-1:0]   writedata;
    logic [BYTEEN_W-1:0] byteen;
    logic [NUMBLK_W-1:0] numblocks;
    prefetch_t           prefetch;
    logic                wren;
  } bus_req_t;

endpackage
